// ==== list.f ====
verilog/drive_pkg.sv
verilog/pwm_pkg.sv
verilog/motor_cmd_if.sv
verilog/tracker_sensor.sv
verilog/motor_drive.sv
verilog/pwm_gen.sv
verilog/line_follower.sv
verification/line_follower_properties.sv
verification/tb_line_follower.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the line follower testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_line_follower \
    -f list.f \
    -o sim_line_follower

./obj_dir/sim_line_follower > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"

// ==== verification/tb_line_follower.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_line_follower import drive_pkg::*, pwm_pkg::*; ();

    localparam int unsigned clk_freq_hz   = 64000;
    localparam int unsigned pwm_freq_hz   = 1000;
    localparam int unsigned sample_period = 16;
    localparam int unsigned pwm_period    = clk_freq_hz / pwm_freq_hz;
    localparam int unsigned mode_timeout  = 4 * sample_period;
    localparam int unsigned rise_timeout  = 3 * pwm_period;
    localparam int unsigned done_timeout  = 8 * pwm_period;
    localparam logic [15:0] lfsr_seed     = 16'd57100;

    typedef struct packed {
        drive_mode_t mode;
        logic        left_forward;
        logic        right_forward;
        duty_t       left_duty;
        duty_t       right_duty;
    } expect_t;

    logic        clk = 1'b0;
    logic        reset;
    logic [2:0]  sensor;
    logic        pwm_left;
    logic        pwm_right;
    logic        dir_left;
    logic        dir_right;
    drive_mode_t mode;

    expect_t     exp;
    drive_mode_t ref_mode;
    int          errors     = 0;
    int          checks     = 0;
    int          tests      = 0;
    int          req_count  = 0;
    int          done_count = 0;
    logic [2:0]  decodable [7] = '{3'b000, 3'b001, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};

    always #20 clk = ~clk;

    line_follower #(
        .clk_freq_hz   (clk_freq_hz),
        .pwm_freq_hz   (pwm_freq_hz),
        .sample_period (sample_period)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .sensor    (sensor),
        .pwm_left  (pwm_left),
        .pwm_right (pwm_right),
        .dir_left  (dir_left),
        .dir_right (dir_right),
        .mode      (mode)
    );

    bind tracker_sensor line_follower_properties #(.width(3)) i_sensor_props (
        .clk    (clk),
        .reset  (reset),
        .strobe (mode_strobe),
        .fields (mode)
    );

    bind motor_drive line_follower_properties #(.width(22)) i_cmd_props (
        .clk    (clk),
        .reset  (reset),
        .strobe (cmd.update),
        .fields ({cmd.left_duty, cmd.right_duty, cmd.left_forward, cmd.right_forward})
    );

    // ********************
    // Reference model
    // ********************

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    function automatic expect_t expected_outputs(input logic [2:0] pattern,
                                                 input drive_mode_t prev);
        expect_t r;
        r.left_forward  = 1'b1;
        r.right_forward = 1'b1;
        r.left_duty     = duty_width'(speed_straight);
        r.right_duty    = duty_width'(speed_straight);
        case (pattern)  // Left tracker in bit 2, right tracker in bit 0.
            3'b010, 3'b111: r.mode = mode_straight;
            3'b110:         r.mode = mode_turn_left;
            3'b011:         r.mode = mode_turn_right;
            3'b100:         r.mode = mode_sharp_left;
            3'b001:         r.mode = mode_sharp_right;
            3'b000:         r.mode = mode_back;
            default:        r.mode = prev;
        endcase
        case (r.mode)
            mode_turn_left: begin
                r.left_duty  = duty_width'(speed_turn_in);
                r.right_duty = duty_width'(speed_turn_out);
            end
            mode_turn_right: begin
                r.left_duty  = duty_width'(speed_turn_out);
                r.right_duty = duty_width'(speed_turn_in);
            end
            mode_sharp_left: begin
                r.left_duty    = duty_width'(speed_sharp_in);
                r.right_duty   = duty_width'(speed_sharp_out);
                r.left_forward = 1'b0;
            end
            mode_sharp_right: begin
                r.left_duty     = duty_width'(speed_sharp_out);
                r.right_duty    = duty_width'(speed_sharp_in);
                r.right_forward = 1'b0;
            end
            mode_back: begin
                r.left_duty     = duty_width'(speed_back);
                r.right_duty    = duty_width'(speed_back);
                r.left_forward  = 1'b0;
                r.right_forward = 1'b0;
            end
            default: ;
        endcase
        return r;
    endfunction

    // High cycles in one PWM period for a given duty.
    function automatic int unsigned expected_high(input duty_t duty);
        return (pwm_period * 32'(duty)) / duty_full_scale;
    endfunction

    // ********************
    // Output comparison
    // ********************

    task automatic measure_and_compare();
        int unsigned waited;
        int unsigned high_left;
        int unsigned high_right;
        logic        prev;
        logic        rose;
        drive_mode_t want;
        want   = exp.mode;
        waited = 0;
        while (mode !== want && waited < mode_timeout) begin
            @(negedge clk);
            waited++;
        end
        checks = checks + 5;
        if (mode !== want) begin
            $display("Timeout: mode did not settle to %s within %0d cycles", want.name(),
                     mode_timeout);
            errors++;
        end
        repeat (3) @(negedge clk); // New duties reach pwm_gen one cycle after the strobe.
        prev   = pwm_left;
        rose   = 1'b0;
        waited = 0;
        while (!rose && waited < rise_timeout) begin
            @(negedge clk);
            waited++;
            rose = !prev && pwm_left;
            prev = pwm_left;
        end
        if (!rose) begin
            $display("Timeout: no rising edge on pwm_left within %0d cycles", rise_timeout);
            errors++;
        end
        high_left  = 0;
        high_right = 0;
        for (int unsigned i = 0; i < pwm_period; i++) begin
            if (pwm_left) begin
                high_left++;
            end
            if (pwm_right) begin
                high_right++;
            end
            @(negedge clk);
        end
        if (dir_left !== exp.left_forward) begin
            $display("MISMATCH at %0t: dir_left is %b, expected %b", $time, dir_left,
                     exp.left_forward);
            errors++;
        end
        if (dir_right !== exp.right_forward) begin
            $display("MISMATCH at %0t: dir_right is %b, expected %b", $time, dir_right,
                     exp.right_forward);
            errors++;
        end
        if (high_left != expected_high(exp.left_duty)) begin
            $display("MISMATCH at %0t: left high count %0d, expected %0d", $time, high_left,
                     expected_high(exp.left_duty));
            errors++;
        end
        if (high_right != expected_high(exp.right_duty)) begin
            $display("MISMATCH at %0t: right high count %0d, expected %0d", $time, high_right,
                     expected_high(exp.right_duty));
            errors++;
        end
    endtask

    initial begin : output_compare
        forever begin
            @(negedge clk);
            if (done_count != req_count) begin
                measure_and_compare();
                done_count = req_count;
            end
        end
    end

    // ********************
    // Stimulus
    // ********************

    task automatic request_check();
        int unsigned waited;
        waited = 0;
        req_count++;
        while (done_count != req_count && waited < done_timeout) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (done_count != req_count) begin
            $display("Timeout: output comparison did not finish within %0d cycles", done_timeout);
            errors++;
        end
    endtask

    // Holds a pattern for three sample periods, then has the outputs compared.
    task automatic apply_pattern(input logic [2:0] pattern);
        sensor   = pattern;
        exp      = expected_outputs(pattern, ref_mode);
        ref_mode = exp.mode;
        repeat (3 * sample_period) begin
            @(posedge clk);
            #5;
        end
        request_check();
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        $display("Test %0d, %s: %0d errors", tests, name, errors - start_errors);
    endtask

    initial begin : stimulus
        logic [2:0]  pattern;
        logic [15:0] lfsr;
        int          test_errors;
        sensor   = 3'b101; // No candidate, so nothing is accepted yet.
        reset    = 1'b1;
        ref_mode = mode_straight;
        lfsr     = lfsr_seed;
        repeat (16) @(posedge clk);
        #5;
        reset = 1'b0;

        test_errors = errors;
        for (int i = 0; i < 3 * sample_period; i++) begin
            @(posedge clk);
            #5;
            checks++;
            if ({pwm_left, pwm_right, dir_left, dir_right} !== 4'b0000
                    || mode !== mode_straight) begin
                $display("MISMATCH at %0t: outputs not idle before the first accepted mode", $time);
                errors++;
            end
        end
        report_test("idle after reset", test_errors);

        test_errors = errors;
        for (int k = 0; k < 7; k++) begin
            apply_pattern(decodable[k]);
        end
        report_test("decodable patterns", test_errors);

        test_errors = errors;
        apply_pattern(3'b110);
        sensor = 3'b001;
        for (int i = 0; i < 4 * sample_period; i++) begin
            if (i == sample_period) begin
                sensor = 3'b110;
            end
            @(posedge clk);
            #5;
            checks++;
            if (mode !== ref_mode) begin
                $display("MISMATCH at %0t: one-sample glitch changed mode to %s", $time,
                         mode.name());
                errors++;
            end
        end
        report_test("glitch filter", test_errors);

        test_errors = errors;
        apply_pattern(3'b100);
        apply_pattern(3'b101);
        report_test("left and right hold", test_errors);

        test_errors = errors;
        for (int n = 0; n < 40; n++) begin
            for (int b = 0; b < 3; b++) begin
                lfsr       = lfsr_step(lfsr);
                pattern[b] = lfsr[0];
            end
            apply_pattern(pattern);
        end
        report_test("random patterns", test_errors);

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/line_follower_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_follower_properties #(
    parameter int unsigned width = 3
) (
    input logic             clk,
    input logic             reset,
    input logic             strobe,
    input logic [width-1:0] fields
);

    // ********************
    // Strobe rules
    // ********************

    // A strobe never lasts longer than one cycle.
    strobe_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        strobe |=> !strobe
    ) else $error("strobe stayed high for a second cycle");

    // The carried fields move only together with their strobe.
    fields_change_on_strobe: assert property (
        @(posedge clk) disable iff (reset)
        !$stable(fields) |-> strobe
    ) else $error("fields changed without a strobe");

    // ********************
    // Reset rules
    // ********************

    // Everything sits at zero while reset is applied.
    reset_values: assert property (
        @(posedge clk)
        $past(reset) |-> (!strobe && fields == '0)
    ) else $error("strobe or fields not cleared by reset");

endmodule

`default_nettype wire

// ==== verilog/line_follower.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_follower import drive_pkg::*; #(
    parameter int unsigned clk_freq_hz   = 100_000_000,
    parameter int unsigned pwm_freq_hz   = 25_000,
    parameter int unsigned sample_period = 100000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [2:0]  sensor,
    output logic        pwm_left,
    output logic        pwm_right,
    output logic        dir_left,
    output logic        dir_right,
    output drive_mode_t mode
);

    logic mode_strobe;

    motor_cmd_if cmd ();

    tracker_sensor #(
        .sample_period (sample_period)
    ) i_tracker_sensor (
        .clk         (clk),
        .reset       (reset),
        .sensor      (sensor),
        .mode        (mode),
        .mode_strobe (mode_strobe)
    );

    motor_drive i_motor_drive (
        .clk         (clk),
        .reset       (reset),
        .mode        (mode),
        .mode_strobe (mode_strobe),
        .cmd         (cmd)
    );

    // ********************
    // Wheel outputs
    // ********************

    pwm_gen #(
        .clk_freq_hz (clk_freq_hz),
        .pwm_freq_hz (pwm_freq_hz)
    ) i_pwm_left (
        .clk   (clk),
        .reset (reset),
        .duty  (cmd.left_duty),
        .pwm   (pwm_left)
    );

    pwm_gen #(
        .clk_freq_hz (clk_freq_hz),
        .pwm_freq_hz (pwm_freq_hz)
    ) i_pwm_right (
        .clk   (clk),
        .reset (reset),
        .duty  (cmd.right_duty),
        .pwm   (pwm_right)
    );

    assign dir_left  = cmd.left_forward;  // High means forward.
    assign dir_right = cmd.right_forward;

endmodule

`default_nettype wire

// ==== verilog/pwm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pwm_gen import pwm_pkg::*; #(
    parameter int unsigned clk_freq_hz = 100_000_000,
    parameter int unsigned pwm_freq_hz = 25_000
) (
    input  logic  clk,
    input  logic  reset,
    input  duty_t duty,
    output logic  pwm
);

    localparam int unsigned prod_width = count_width + duty_width;

    // The period in clock cycles is fixed at elaboration.
    localparam int unsigned period = clk_freq_hz / pwm_freq_hz;
    localparam logic [count_width-1:0] period_last = count_width'(period - 1);
    localparam logic [prod_width-1:0]  period_wide = prod_width'(period);

    logic [count_width-1:0] count;
    logic [count_width-1:0] threshold;
    logic [prod_width-1:0]  product;
    logic                   wrap;

    assign wrap    = (count == period_last);
    assign product = period_wide * prod_width'(duty);

    // ********************
    // Period counter
    // ********************

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count     <= '0;
            threshold <= '0;
        end else if (wrap) begin
            count     <= '0;
            // Full scale is a power of two, so this is a plain shift.
            threshold <= count_width'(product / duty_full_scale);
        end else begin
            count <= count + 1'b1;
        end
    end

    // High for the first threshold cycles of every period.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (count < threshold);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/motor_drive.sv ====
`timescale 1ns/1ps
`default_nettype none

module motor_drive import drive_pkg::*, pwm_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  drive_mode_t    mode,
    input  logic           mode_strobe,
    motor_cmd_if.source    cmd
);

    localparam duty_t duty_straight  = duty_width'(speed_straight);
    localparam duty_t duty_turn_in   = duty_width'(speed_turn_in);
    localparam duty_t duty_turn_out  = duty_width'(speed_turn_out);
    localparam duty_t duty_sharp_in  = duty_width'(speed_sharp_in);
    localparam duty_t duty_sharp_out = duty_width'(speed_sharp_out);
    localparam duty_t duty_back      = duty_width'(speed_back);

    duty_t next_left_duty;
    duty_t next_right_duty;
    logic  next_left_forward;
    logic  next_right_forward;

    // ********************
    // Speed table
    // ********************

    always_comb begin
        next_left_duty     = duty_straight;
        next_right_duty    = duty_straight;
        next_left_forward  = 1'b1;
        next_right_forward = 1'b1;
        case (mode)
            mode_straight: begin
                next_left_duty  = duty_straight;
                next_right_duty = duty_straight;
            end
            mode_turn_left: begin
                next_left_duty  = duty_turn_in;
                next_right_duty = duty_turn_out;
            end
            mode_turn_right: begin
                next_left_duty  = duty_turn_out;
                next_right_duty = duty_turn_in;
            end
            mode_sharp_left: begin
                next_left_duty    = duty_sharp_in;
                next_right_duty   = duty_sharp_out;
                next_left_forward = 1'b0; // Pivot on the left wheel.
            end
            mode_sharp_right: begin
                next_left_duty     = duty_sharp_out;
                next_right_duty    = duty_sharp_in;
                next_right_forward = 1'b0;
            end
            mode_back: begin
                next_left_duty     = duty_back;
                next_right_duty    = duty_back;
                next_left_forward  = 1'b0;
                next_right_forward = 1'b0;
            end
            default: ;
        endcase
    end

    // Fields move only together with the update strobe.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd.left_duty     <= '0;
            cmd.right_duty    <= '0;
            cmd.left_forward  <= 1'b0;
            cmd.right_forward <= 1'b0;
            cmd.update        <= 1'b0;
        end else begin
            cmd.update <= mode_strobe;
            if (mode_strobe) begin
                cmd.left_duty     <= next_left_duty;
                cmd.right_duty    <= next_right_duty;
                cmd.left_forward  <= next_left_forward;
                cmd.right_forward <= next_right_forward;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tracker_sensor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tracker_sensor import drive_pkg::*; #(
    parameter int unsigned sample_period = 100000
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [2:0]  sensor,
    output drive_mode_t mode,
    output logic        mode_strobe
);

    localparam int unsigned tick_width = (sample_period > 1) ? $clog2(sample_period) : 1;
    localparam logic [tick_width-1:0] tick_last = tick_width'(sample_period - 1);

    logic [tick_width-1:0] tick_count;
    logic                  tick;
    logic [2:0]            sensor_meta;
    logic [2:0]            sensor_sync;
    drive_mode_t           candidate;
    logic                  candidate_valid;
    drive_mode_t           prev_candidate;
    logic                  prev_valid;

    // ********************
    // Sample tick
    // ********************

    assign tick = (tick_count == tick_last);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_count <= '0;
        end else if (tick) begin
            tick_count <= '0;
        end else begin
            tick_count <= tick_count + 1'b1;
        end
    end

    // The tracker pins are asynchronous to clk.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sensor_meta <= '0;
            sensor_sync <= '0;
        end else begin
            sensor_meta <= sensor;
            sensor_sync <= sensor_meta;
        end
    end

    // ********************
    // Pattern decode
    // ********************

    always_comb begin
        candidate       = mode_straight;
        candidate_valid = 1'b1;
        case (sensor_sync)
            pat_middle, pat_all: candidate = mode_straight;
            pat_left_mid:        candidate = mode_turn_left;
            pat_mid_right:       candidate = mode_turn_right;
            pat_left:            candidate = mode_sharp_left;
            pat_right:           candidate = mode_sharp_right;
            pat_none:            candidate = mode_back;
            pat_left_right:      candidate_valid = 1'b0;
            default:             candidate_valid = 1'b0;
        endcase
    end

    // A mode is taken only when two ticks in a row agree on it.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_candidate <= mode_straight;
            prev_valid     <= 1'b0;
            mode           <= mode_straight;
            mode_strobe    <= 1'b0;
        end else begin
            mode_strobe <= 1'b0;
            if (tick) begin
                prev_candidate <= candidate;
                prev_valid     <= candidate_valid;
                if (candidate_valid && prev_valid && (candidate == prev_candidate)) begin
                    mode        <= candidate;
                    mode_strobe <= 1'b1; // Pulses even when the mode is unchanged.
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/motor_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface motor_cmd_if import pwm_pkg::*; ();

    duty_t left_duty;
    duty_t right_duty;
    logic  left_forward;
    logic  right_forward;
    logic  update;  // One cycle high when the fields above take new values.

    modport source (
        output left_duty,
        output right_duty,
        output left_forward,
        output right_forward,
        output update
    );

    modport sink (
        input left_duty,
        input right_duty,
        input left_forward,
        input right_forward,
        input update
    );

endinterface

`default_nettype wire

// ==== verilog/pwm_pkg.sv ====
`default_nettype none

package pwm_pkg;

    // Width of one duty value.
    localparam int unsigned duty_width = 10;

    // A duty of duty_full_scale would mean the output is always high.
    localparam int unsigned duty_full_scale = 1024;

    // Width of the period counter inside the generator.
    localparam int unsigned count_width = 32;

    typedef logic [duty_width-1:0] duty_t;

endpackage

`default_nettype wire

// ==== verilog/drive_pkg.sv ====
`default_nettype none

package drive_pkg;

    // ********************
    // Driving modes
    // ********************

    typedef enum logic [2:0] {
        mode_straight,
        mode_turn_left,
        mode_turn_right,
        mode_sharp_left,
        mode_sharp_right,
        mode_back
    } drive_mode_t;

    // ********************
    // Sensor patterns
    // ********************

    // Bit 2 is the left tracker, bit 1 the middle and bit 0 the right one.
    localparam logic [2:0] pat_none       = 3'b000;
    localparam logic [2:0] pat_right      = 3'b001;
    localparam logic [2:0] pat_middle     = 3'b010;
    localparam logic [2:0] pat_mid_right  = 3'b011;
    localparam logic [2:0] pat_left       = 3'b100;
    localparam logic [2:0] pat_left_right = 3'b101; // The mode holds on this pattern.
    localparam logic [2:0] pat_left_mid   = 3'b110;
    localparam logic [2:0] pat_all        = 3'b111;

    // ********************
    // Wheel speeds
    // ********************

    // Duty values out of a full scale of 1024.
    localparam int unsigned speed_straight  = 1023;
    localparam int unsigned speed_turn_in   = 723;
    localparam int unsigned speed_turn_out  = 1023;
    localparam int unsigned speed_sharp_in  = 512;  // Inner wheel runs backwards.
    localparam int unsigned speed_sharp_out = 1023;
    localparam int unsigned speed_back      = 767;

endpackage

`default_nettype wire
